//--- Bender.yml
package:
  name: mm_accel

sources:
  - include_dirs:
      - logic
    files:
      - logic/mm_accel_pkg.sv
      - logic/operand_buffer.sv
      - logic/mac_cell.sv
      - logic/mm_engine.sv
      - logic/dma_engine.sv
      - logic/mm_accel_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/mm_accel_checker.sv
      - verif/tb_mm_accel.sv

//--- logic/dma_engine.sv
/*
 * dma sequencer of the accelerator
 * interleaved A/B fetch into the buffers, matrix engine handshake,
 * and store of the sixteen C words
 */
`timescale 1ns/10ps
`include "mm_accel_cfg.svh"

module dma_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [31:0]           mat_a_addr_i,
    input  logic [31:0]           mat_b_addr_i,
    input  logic [31:0]           mat_c_addr_i,
    input  logic [7:0]            mat_width_i,
    input  logic                  mem_rd_valid_i,
    input  logic [`MM_ROW_W-1:0]  mem_rd_data_i,
    input  logic                  mm_done_i,
    input  mm_accel_pkg::acc_t    acc_00_i,
    input  mm_accel_pkg::acc_t    acc_01_i,
    input  mm_accel_pkg::acc_t    acc_02_i,
    input  mm_accel_pkg::acc_t    acc_03_i,
    input  mm_accel_pkg::acc_t    acc_10_i,
    input  mm_accel_pkg::acc_t    acc_11_i,
    input  mm_accel_pkg::acc_t    acc_12_i,
    input  mm_accel_pkg::acc_t    acc_13_i,
    input  mm_accel_pkg::acc_t    acc_20_i,
    input  mm_accel_pkg::acc_t    acc_21_i,
    input  mm_accel_pkg::acc_t    acc_22_i,
    input  mm_accel_pkg::acc_t    acc_23_i,
    input  mm_accel_pkg::acc_t    acc_30_i,
    input  mm_accel_pkg::acc_t    acc_31_i,
    input  mm_accel_pkg::acc_t    acc_32_i,
    input  mm_accel_pkg::acc_t    acc_33_i,
    output logic                  done_o,
    output logic                  mem_rd_req_o,
    output logic [31:0]           mem_rd_addr_o,
    output logic                  mem_wr_o,
    output logic [31:0]           mem_wr_addr_o,
    output logic [`MM_ROW_W-1:0]  mem_wr_data_o,
    output logic                  buf_a_wr_en_o,
    output logic                  buf_b_wr_en_o,
    output logic [`MM_BUF_AW-1:0] buf_wr_addr_o,
    output logic [`MM_ROW_W-1:0]  buf_wr_data_o,
    output logic                  mm_start_o
);

    // request/response count reaches 2K, K up to 2**MM_BUF_AW
    localparam int CNT_W = `MM_BUF_AW + 2;
    // one index per C element
    localparam int ST_W  = 2 * $clog2(`MM_SA);

    mm_accel_pkg::dma_state_t state_q;

    logic [CNT_W-1:0]     req_cnt_q;
    logic [CNT_W-1:0]     rsp_cnt_q;
    logic [ST_W-1:0]      st_cnt_q;
    logic [31:0]          a_base_q;
    logic [31:0]          b_base_q;
    logic [31:0]          c_base_q;
    logic [`MM_BUF_AW:0]  k_q;
    logic [CNT_W-1:0]     two_k;
    mm_accel_pkg::acc_t   acc_sel;

    assign two_k = {k_q, 1'b0};

    // run parameters, held for the whole run
    always_ff @(posedge clk) begin
        if (state_q == mm_accel_pkg::IDLE && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
            k_q      <= mat_width_i[`MM_BUF_AW:0];
        end
    end

    // sequencer and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= mm_accel_pkg::IDLE;
            req_cnt_q  <= '0;
            rsp_cnt_q  <= '0;
            st_cnt_q   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state_q)
                mm_accel_pkg::IDLE: begin
                    // start outside IDLE falls through here unseen
                    if (start_i) begin
                        state_q   <= mm_accel_pkg::LOAD;
                        req_cnt_q <= '0;
                        rsp_cnt_q <= '0;
                    end
                end
                mm_accel_pkg::LOAD: begin
                    // requests and responses advance independently
                    if (mem_rd_req_o) begin
                        req_cnt_q <= req_cnt_q + 1'b1;
                    end
                    if (mem_rd_valid_i) begin
                        rsp_cnt_q <= rsp_cnt_q + 1'b1;
                    end
                    // last response is being written this cycle
                    if (rsp_cnt_q == two_k) begin
                        state_q    <= mm_accel_pkg::WAIT_MM;
                        mm_start_o <= 1'b1;
                    end
                end
                mm_accel_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q  <= mm_accel_pkg::STORE;
                        st_cnt_q <= '0;
                    end
                end
                mm_accel_pkg::STORE: begin
                    st_cnt_q <= st_cnt_q + 1'b1;
                    if (st_cnt_q == '1) begin
                        state_q <= mm_accel_pkg::IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= mm_accel_pkg::IDLE;
                end
            endcase
        end
    end

    // read requests, even count to A, odd count to B
    assign mem_rd_req_o  = (state_q == mm_accel_pkg::LOAD) && (req_cnt_q != two_k);
    assign mem_rd_addr_o = (req_cnt_q[0] ? b_base_q : a_base_q)
                         + 32'({req_cnt_q[CNT_W-1:1], 2'b00});

    // in-order responses, so the response count names the target
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wr_en_o <= 1'b0;
            buf_b_wr_en_o <= 1'b0;
        end else begin
            buf_a_wr_en_o <= mem_rd_valid_i && !rsp_cnt_q[0];
            buf_b_wr_en_o <= mem_rd_valid_i && rsp_cnt_q[0];
        end
    end

    // registered row and entry index for the buffer write
    always_ff @(posedge clk) begin
        buf_wr_data_o <= mem_rd_data_i;
        buf_wr_addr_o <= rsp_cnt_q[CNT_W-2:1];
    end

    // row-major accumulator pick
    always_comb begin
        case (st_cnt_q)
            4'd0:    acc_sel = acc_00_i;
            4'd1:    acc_sel = acc_01_i;
            4'd2:    acc_sel = acc_02_i;
            4'd3:    acc_sel = acc_03_i;
            4'd4:    acc_sel = acc_10_i;
            4'd5:    acc_sel = acc_11_i;
            4'd6:    acc_sel = acc_12_i;
            4'd7:    acc_sel = acc_13_i;
            4'd8:    acc_sel = acc_20_i;
            4'd9:    acc_sel = acc_21_i;
            4'd10:   acc_sel = acc_22_i;
            4'd11:   acc_sel = acc_23_i;
            4'd12:   acc_sel = acc_30_i;
            4'd13:   acc_sel = acc_31_i;
            4'd14:   acc_sel = acc_32_i;
            default: acc_sel = acc_33_i;
        endcase
    end

    // one C word per STORE cycle, sign-extended to the bus width
    assign mem_wr_o      = (state_q == mm_accel_pkg::STORE);
    assign mem_wr_addr_o = c_base_q + 32'({st_cnt_q, 2'b00});
    assign mem_wr_data_o = {{(`MM_ROW_W - `MM_ACC_W){acc_sel[`MM_ACC_W-1]}}, acc_sel};

endmodule

//--- logic/mac_cell.sv
/*
 * signed multiply-accumulate cell of the output-stationary array
 */
`timescale 1ns/10ps
`include "mm_accel_cfg.svh"

module mac_cell (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear_i,
    input  logic                 en_i,
    input  mm_accel_pkg::elem_t  a_i,
    input  mm_accel_pkg::elem_t  b_i,
    output mm_accel_pkg::acc_t   acc_o
);

    // full-precision signed product
    logic signed [2*`MM_DW-1:0] prod;

    assign prod = a_i * b_i;

    // clear wins over accumulate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_o <= '0;
        end else if (clear_i) begin
            acc_o <= '0;
        end else if (en_i) begin
            acc_o <= acc_o + mm_accel_pkg::acc_t'(prod);
        end
    end

endmodule

//--- logic/mm_accel_cfg.svh
/*
 * element, array, buffer and accumulator sizing macros
 * shared by the package and every RTL block of the accelerator
 */
`ifndef MM_ACCEL_CFG_SVH
`define MM_ACCEL_CFG_SVH

// signed matrix element width in bits
`define MM_DW 8

// cells per row and per column of the square array
`define MM_SA 4

// operand buffer address width, 64 entries so K up to 64
`define MM_BUF_AW 6

// one buffer entry, also one memory data word
`define MM_ROW_W (`MM_DW * `MM_SA)

// full product width plus headroom for 2**MM_BUF_AW worst-case sums
`define MM_ACC_W (2 * `MM_DW + `MM_BUF_AW)

`endif

//--- logic/mm_accel_pkg.sv
/*
 * shared types of the accelerator
 * dma sequencer state, signed element and signed accumulator
 */
`include "mm_accel_cfg.svh"

package mm_accel_pkg;

    // dma sequencer phases
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOAD    = 2'd1,
        WAIT_MM = 2'd2,
        STORE   = 2'd3
    } dma_state_t;

    // one matrix element as unpacked from a byte lane
    typedef logic signed [`MM_DW-1:0] elem_t;

    // per-cell running sum
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

endpackage

//--- logic/mm_accel_top.sv
/*
 * accelerator top level
 * dma engine, operand buffers A and B, matrix engine
 */
`timescale 1ns/10ps
`include "mm_accel_cfg.svh"

module mm_accel_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          mat_a_addr_i,
    input  logic [31:0]          mat_b_addr_i,
    input  logic [31:0]          mat_c_addr_i,
    input  logic [7:0]           mat_width_i,
    input  logic                 start_i,
    output logic                 done_o,
    output logic                 mem_rd_req_o,
    output logic [31:0]          mem_rd_addr_o,
    input  logic                 mem_rd_valid_i,
    input  logic [`MM_ROW_W-1:0] mem_rd_data_i,
    output logic                 mem_wr_o,
    output logic [31:0]          mem_wr_addr_o,
    output logic [`MM_ROW_W-1:0] mem_wr_data_o
);

    // buffer fill path
    logic                  buf_a_wr_en;
    logic                  buf_b_wr_en;
    logic [`MM_BUF_AW-1:0] buf_wr_addr;
    logic [`MM_ROW_W-1:0]  buf_wr_data;
    // buffer read path
    logic [`MM_BUF_AW-1:0] buf_a_rd_addr;
    logic [`MM_BUF_AW-1:0] buf_b_rd_addr;
    logic [`MM_ROW_W-1:0]  buf_a_rd_data;
    logic [`MM_ROW_W-1:0]  buf_b_rd_data;
    // engine handshake and results
    logic                  mm_start;
    logic                  mm_done;
    mm_accel_pkg::acc_t    acc_00, acc_01, acc_02, acc_03;
    mm_accel_pkg::acc_t    acc_10, acc_11, acc_12, acc_13;
    mm_accel_pkg::acc_t    acc_20, acc_21, acc_22, acc_23;
    mm_accel_pkg::acc_t    acc_30, acc_31, acc_32, acc_33;

    dma_engine u_dma (
        .clk (clk), .rst_n (rst_n), .start_i (start_i), .done_o (done_o),
        .mat_a_addr_i (mat_a_addr_i), .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i), .mat_width_i (mat_width_i),
        .mem_rd_req_o (mem_rd_req_o), .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_valid_i (mem_rd_valid_i), .mem_rd_data_i (mem_rd_data_i),
        .mem_wr_o (mem_wr_o), .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .buf_a_wr_en_o (buf_a_wr_en), .buf_b_wr_en_o (buf_b_wr_en),
        .buf_wr_addr_o (buf_wr_addr), .buf_wr_data_o (buf_wr_data),
        .mm_start_o (mm_start), .mm_done_i (mm_done),
        .acc_00_i (acc_00), .acc_01_i (acc_01), .acc_02_i (acc_02), .acc_03_i (acc_03),
        .acc_10_i (acc_10), .acc_11_i (acc_11), .acc_12_i (acc_12), .acc_13_i (acc_13),
        .acc_20_i (acc_20), .acc_21_i (acc_21), .acc_22_i (acc_22), .acc_23_i (acc_23),
        .acc_30_i (acc_30), .acc_31_i (acc_31), .acc_32_i (acc_32), .acc_33_i (acc_33)
    );

    // columns of A
    operand_buffer buf_a (
        .clk (clk), .wr_en_i (buf_a_wr_en), .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data), .rd_addr_i (buf_a_rd_addr), .rd_data_o (buf_a_rd_data)
    );

    // rows of B
    operand_buffer buf_b (
        .clk (clk), .wr_en_i (buf_b_wr_en), .wr_addr_i (buf_wr_addr),
        .wr_data_i (buf_wr_data), .rd_addr_i (buf_b_rd_addr), .rd_data_o (buf_b_rd_data)
    );

    mm_engine u_mm (
        .clk (clk), .rst_n (rst_n), .start_i (mm_start), .mat_width_i (mat_width_i),
        .buf_a_rd_data_i (buf_a_rd_data), .buf_b_rd_data_i (buf_b_rd_data),
        .buf_a_rd_addr_o (buf_a_rd_addr), .buf_b_rd_addr_o (buf_b_rd_addr),
        .done_o (mm_done),
        .acc_00_o (acc_00), .acc_01_o (acc_01), .acc_02_o (acc_02), .acc_03_o (acc_03),
        .acc_10_o (acc_10), .acc_11_o (acc_11), .acc_12_o (acc_12), .acc_13_o (acc_13),
        .acc_20_o (acc_20), .acc_21_o (acc_21), .acc_22_o (acc_22), .acc_23_o (acc_23),
        .acc_30_o (acc_30), .acc_31_o (acc_31), .acc_32_o (acc_32), .acc_33_o (acc_33)
    );

endmodule

//--- logic/mm_engine.sv
/*
 * matrix engine, walks both buffers over K entries
 * and feeds the 4x4 array of mac cells, done after the last sum
 */
`timescale 1ns/10ps
`include "mm_accel_cfg.svh"

module mm_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [7:0]            mat_width_i,
    input  logic [`MM_ROW_W-1:0]  buf_a_rd_data_i,
    input  logic [`MM_ROW_W-1:0]  buf_b_rd_data_i,
    output logic [`MM_BUF_AW-1:0] buf_a_rd_addr_o,
    output logic [`MM_BUF_AW-1:0] buf_b_rd_addr_o,
    output logic                  done_o,
    output mm_accel_pkg::acc_t    acc_00_o,
    output mm_accel_pkg::acc_t    acc_01_o,
    output mm_accel_pkg::acc_t    acc_02_o,
    output mm_accel_pkg::acc_t    acc_03_o,
    output mm_accel_pkg::acc_t    acc_10_o,
    output mm_accel_pkg::acc_t    acc_11_o,
    output mm_accel_pkg::acc_t    acc_12_o,
    output mm_accel_pkg::acc_t    acc_13_o,
    output mm_accel_pkg::acc_t    acc_20_o,
    output mm_accel_pkg::acc_t    acc_21_o,
    output mm_accel_pkg::acc_t    acc_22_o,
    output mm_accel_pkg::acc_t    acc_23_o,
    output mm_accel_pkg::acc_t    acc_30_o,
    output mm_accel_pkg::acc_t    acc_31_o,
    output mm_accel_pkg::acc_t    acc_32_o,
    output mm_accel_pkg::acc_t    acc_33_o
);

    logic                  run_q;
    logic                  vld_q;
    logic [`MM_BUF_AW-1:0] rd_addr_q;
    logic [`MM_BUF_AW-1:0] k_last_q;
    mm_accel_pkg::elem_t   a_lane [`MM_SA];
    mm_accel_pkg::elem_t   b_lane [`MM_SA];
    mm_accel_pkg::acc_t    acc    [`MM_SA][`MM_SA];

    // read walk over entries 0..K-1, K=64 wraps to last index 63
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            vld_q     <= 1'b0;
            done_o    <= 1'b0;
            rd_addr_q <= '0;
            k_last_q  <= '0;
        end else begin
            // data valid one cycle behind the address
            vld_q  <= run_q;
            // last accumulate is the cycle where run has already dropped
            done_o <= vld_q && !run_q;
            if (start_i) begin
                run_q     <= 1'b1;
                rd_addr_q <= '0;
                k_last_q  <= `MM_BUF_AW'(mat_width_i - 8'd1);
            end else if (run_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                if (rd_addr_q == k_last_q) begin
                    run_q <= 1'b0;
                end
            end
        end
    end

    // both buffers share the entry index
    assign buf_a_rd_addr_o = rd_addr_q;
    assign buf_b_rd_addr_o = rd_addr_q;

    // A lane i is row i, B lane j is column j
    for (genvar i = 0; i < `MM_SA; i++) begin : g_lane
        assign a_lane[i] = buf_a_rd_data_i[i*`MM_DW +: `MM_DW];
        assign b_lane[i] = buf_b_rd_data_i[i*`MM_DW +: `MM_DW];
    end

    for (genvar i = 0; i < `MM_SA; i++) begin : g_row
        for (genvar j = 0; j < `MM_SA; j++) begin : g_col
            mac_cell u_cell (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (start_i),
                .en_i    (vld_q),
                .a_i     (a_lane[i]),
                .b_i     (b_lane[j]),
                .acc_o   (acc[i][j])
            );
        end
    end

    // sums held until the next start
    assign acc_00_o = acc[0][0];
    assign acc_01_o = acc[0][1];
    assign acc_02_o = acc[0][2];
    assign acc_03_o = acc[0][3];
    assign acc_10_o = acc[1][0];
    assign acc_11_o = acc[1][1];
    assign acc_12_o = acc[1][2];
    assign acc_13_o = acc[1][3];
    assign acc_20_o = acc[2][0];
    assign acc_21_o = acc[2][1];
    assign acc_22_o = acc[2][2];
    assign acc_23_o = acc[2][3];
    assign acc_30_o = acc[3][0];
    assign acc_31_o = acc[3][1];
    assign acc_32_o = acc[3][2];
    assign acc_33_o = acc[3][3];

endmodule

//--- logic/operand_buffer.sv
/*
 * operand buffer, one write port and one registered read port
 * each entry is one packed row of four elements
 */
`timescale 1ns/10ps
`include "mm_accel_cfg.svh"

module operand_buffer (
    input  logic                  clk,
    input  logic                  wr_en_i,
    input  logic [`MM_BUF_AW-1:0] wr_addr_i,
    input  logic [`MM_ROW_W-1:0]  wr_data_i,
    input  logic [`MM_BUF_AW-1:0] rd_addr_i,
    output logic [`MM_ROW_W-1:0]  rd_data_o
);

    localparam int DEPTH = 2 ** `MM_BUF_AW;

    // storage array, written by the dma engine only
    logic [`MM_ROW_W-1:0] mem_q [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // read port, data one cycle after the address
    // a write and a read of one entry in the same cycle returns the old row
    always_ff @(posedge clk) begin
        rd_data_o <= mem_q[rd_addr_i];
    end

endmodule

//--- src.f
+incdir+logic
logic/mm_accel_pkg.sv
logic/operand_buffer.sv
logic/mac_cell.sv
logic/mm_engine.sv
logic/dma_engine.sv
logic/mm_accel_top.sv
verif/mm_accel_checker.sv
verif/tb_mm_accel.sv

//--- verif/mm_accel_checker.sv
/*
 * bound assertions on the dma engine
 * single-cycle mm_start and done pulses, memory strobes only in their phase
 */
`timescale 1ns/10ps

module mm_accel_checker (
    input logic                     clk,
    input logic                     rst_n,
    input mm_accel_pkg::dma_state_t state_i,
    input logic                     mm_start_i,
    input logic                     done_i,
    input logic                     mem_wr_i,
    input logic                     mem_rd_req_i
);

    // assertion failure count
    int fail_cnt = 0;

    a_mm_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_i |=> !mm_start_i)
        else begin
            fail_cnt++;
            $error("mm_start_o high for more than one cycle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o high for more than one cycle");
        end

    // writes only while storing C
    a_wr_in_store: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_i |-> state_i == mm_accel_pkg::STORE)
        else begin
            fail_cnt++;
            $error("mem_wr_o outside STORE");
        end

    // reads only while loading A and B
    a_rd_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_req_i |-> state_i == mm_accel_pkg::LOAD)
        else begin
            fail_cnt++;
            $error("mem_rd_req_o outside LOAD");
        end

endmodule

bind dma_engine mm_accel_checker u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state_q),
    .mm_start_i   (mm_start_o),
    .done_i       (done_o),
    .mem_wr_i     (mem_wr_o),
    .mem_rd_req_i (mem_rd_req_o)
);

//--- verif/tb_mm_accel.sv
/*
 * testbench for the matrix-multiply accelerator
 * clock, reset, in-order memory model with random latency,
 * reference multiply, write compare and reporting
 */
`timescale 1ns/10ps

module tb_mm_accel;

    localparam int          LAT_MAX = 6;
    localparam logic [31:0] SEED    = 32'h08e5_105f;
    localparam int          TIMEOUT = 4000;
    localparam int          N_RUNS  = 3;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] a_addr;
    logic [31:0] b_addr;
    logic [31:0] c_addr;
    logic [7:0]  k_width;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        done;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        wr;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;

    // byte image, pending reads in request order, expected C
    logic [7:0]  mem [logic [31:0]];
    logic [31:0] rd_q_addr [$];
    int          rd_q_due [$];
    int          exp_c [16];
    logic [31:0] lfsr;
    logic [31:0] run_c;
    int          cyc;
    int          due;
    int          last_due;
    int          wr_cnt;
    int          rd_cnt;
    int          done_cnt;
    int          err_cnt;
    int          chk_cnt;
    int          tests_run;
    int          kw;

    mm_accel_top dut (
        .clk (clk), .rst_n (rst_n), .start_i (start), .done_o (done),
        .mat_a_addr_i (a_addr), .mat_b_addr_i (b_addr), .mat_c_addr_i (c_addr),
        .mat_width_i (k_width),
        .mem_rd_req_o (rd_req), .mem_rd_addr_o (rd_addr),
        .mem_rd_valid_i (rd_valid), .mem_rd_data_i (rd_data),
        .mem_wr_o (wr), .mem_wr_addr_o (wr_addr), .mem_wr_data_o (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // unwritten bytes read as zero
    function automatic logic signed [7:0] elem(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : 8'h00;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {elem(addr + 3), elem(addr + 2), elem(addr + 1), elem(addr)};
    endfunction

    // C(i,j) = sum over k of A(i,k) * B(k,j)
    // A column k and B row k both sit at base + 4k with lane i as row i and lane j as column j
    function automatic void ref_matmul(input logic [31:0] a_b, input logic [31:0] b_b,
                                       input int kn);
        int s;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                s = 0;
                for (int k = 0; k < kn; k++) begin
                    s += int'(elem(a_b + 4*k + i)) * int'(elem(b_b + 4*k + j));
                end
                exp_c[4*i + j] = s;
            end
        end
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // mode 0 small counting values, 1 random, else all -128
    task automatic fill_mat(input logic [31:0] base, input int kn, input int mode);
        for (int n = 0; n < 4*kn; n++) begin
            case (mode)
                0:       mem[base + n] = 8'(n % 5 + 1);
                1:       mem[base + n] = 8'(rand_bits(8));
                default: mem[base + n] = 8'h80;
            endcase
        end
    endtask

    // log read requests with an in-order due cycle and store writes
    always @(posedge clk) begin
        cyc++;
        if (rd_req) begin
            due = cyc + int'(rand_bits(3) % LAT_MAX);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rd_q_addr.push_back(rd_addr);
            rd_q_due.push_back(due);
            rd_cnt++;
        end
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                mem[wr_addr + b] = wr_data[8*b +: 8];
            end
        end
    end

    // responses driven on the falling edge and at most one per cycle
    always @(negedge clk) begin
        rd_valid = 1'b0;
        if (rd_q_due.size() > 0 && rd_q_due[0] <= cyc) begin
            rd_valid = 1'b1;
            rd_data  = mem_word(rd_q_addr[0]);
            void'(rd_q_addr.pop_front());
            void'(rd_q_due.pop_front());
        end
    end

    // compare every C write against the reference
    always @(posedge clk) begin
        if (rst_n && wr) begin
            if (wr_cnt < 16) begin
                check_val($sformatf("mem_wr_addr_o[%0d]", wr_cnt), wr_addr, run_c + 4*wr_cnt);
                check_val($sformatf("mem_wr_data_o[%0d]", wr_cnt), wr_data, exp_c[wr_cnt]);
            end
            wr_cnt++;
        end
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    // one run with an optional second start mid-run at moved addresses
    // fixed >= 0 also checks every stored C word against that value
    task automatic run_test(input string name, input logic [31:0] a_b, input logic [31:0] b_b,
                            input logic [31:0] c_b, input int kn, input bit restart,
                            input int fixed);
        int e0;
        int d0;
        int t;
        e0 = err_cnt;
        d0 = done_cnt;
        ref_matmul(a_b, b_b, kn);
        run_c  = c_b;
        wr_cnt = 0;
        rd_cnt = 0;
        @(negedge clk);
        a_addr  = a_b;
        b_addr  = b_b;
        c_addr  = c_b;
        k_width = 8'(kn);
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (restart) begin
            repeat (3) @(negedge clk);
            a_addr = a_b + 32'h0800;
            b_addr = b_b + 32'h0800;
            c_addr = c_b + 32'h0400;
            start  = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        t = 0;
        while (done_cnt == d0 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (done_cnt == d0) begin
            err_cnt++;
            $display("timeout: no done_o pulse in run %0d (%s)", tests_run + 1, name);
        end else begin
            // a stray second run would show up in this quiet period
            repeat (40) @(negedge clk);
            check_val("done_o pulses", done_cnt - d0, 1);
            check_val("mem_wr_o count", wr_cnt, 16);
            check_val("mem_rd_req_o count", rd_cnt, 2*kn);
            if (fixed >= 0) begin
                for (int n = 0; n < 16; n++) begin
                    check_val($sformatf("C word %0d", n), mem_word(c_b + 4*n), fixed);
                end
            end
        end
        tests_run++;
        $display("run %0d %s k=%0d: %s", tests_run, name, kn,
                 (err_cnt == e0) ? "ok" : "errors");
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        a_addr   = '0;
        b_addr   = '0;
        c_addr   = '0;
        k_width  = 8'd1;
        rd_valid = 1'b0;
        rd_data  = '0;
        lfsr     = SEED;
        cyc      = 0;
        last_due = 0;
        wr_cnt   = 0;
        rd_cnt   = 0;
        done_cnt = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        tests_run = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // single entry with small values
        fill_mat(32'h0000_1000, 1, 0);
        fill_mat(32'h0000_2000, 1, 0);
        run_test("k1 small", 32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 1, 1'b0, -1);

        // random width and signed elements
        for (int r = 0; r < N_RUNS; r++) begin
            kw = 1 + int'(rand_bits(6));
            fill_mat(32'h0001_0000, kw, 1);
            fill_mat(32'h0001_1000, kw, 1);
            run_test("random", 32'h0001_0000, 32'h0001_1000, 32'h0001_2000, kw, 1'b0, -1);
        end

        // worst-case magnitude gives 64 * 16384 per word
        fill_mat(32'h0002_0000, 64, 2);
        fill_mat(32'h0002_1000, 64, 2);
        run_test("min elem", 32'h0002_0000, 32'h0002_1000, 32'h0002_2000, 64, 1'b0,
                 64 * 16384);

        // moving word-aligned bases in disjoint regions
        for (int r = 0; r < N_RUNS; r++) begin
            kw = 1 + int'(rand_bits(6));
            a_addr = 32'h0010_0000 + (rand_bits(12) << 2);
            b_addr = 32'h0020_0000 + (rand_bits(12) << 2);
            c_addr = 32'h0030_0000 + (rand_bits(12) << 2);
            fill_mat(a_addr, kw, 1);
            fill_mat(b_addr, kw, 1);
            run_test("new bases", a_addr, b_addr, c_addr, kw, 1'b0, -1);
        end

        // start while busy must be ignored
        fill_mat(32'h0005_0000, 16, 1);
        fill_mat(32'h0005_1000, 16, 1);
        run_test("busy start", 32'h0005_0000, 32'h0005_1000, 32'h0005_2000, 16, 1'b1, -1);

        err_cnt += dut.u_dma.u_chk.fail_cnt;
        $display("runs %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, chk_cnt, err_cnt, dut.u_dma.u_chk.fail_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
